/* wb_cfg_pkg.sv */
// ##############################
// Sizing constants of the per-warp wait buffer
// Referenced by scoped name from the types package and the RTL
// ##############################

package wb_cfg_pkg;

    // Wait-buffer slots per warp
    localparam int unsigned ENTRIES = 4;
    // Index into the slots, used by the dispatch pointer
    localparam int unsigned ENTRY_IDX_W = $clog2(ENTRIES);

    // Instruction tags in flight
    localparam int unsigned NUM_TAGS = 8;
    localparam int unsigned TAG_W = $clog2(NUM_TAGS);

    // Architectural registers per warp
    localparam int unsigned REG_IDX_W = 6;

    // Source operands per instruction
    localparam int unsigned NUM_OPERANDS = 2;

    // Credits run from zero up to ENTRIES inclusive
    localparam int unsigned CREDIT_W = $clog2(ENTRIES + 1);

endpackage

/* wb_types_pkg.sv */
// ##############################
// Vector types shared by the wait-buffer blocks
// Widths come from the sizing package
// ##############################

package wb_types_pkg;

    // Instruction tag, also used as the result tag of the execution units
    typedef logic [wb_cfg_pkg::TAG_W-1:0] tag_t;

    // Register index for destination and operands
    typedef logic [wb_cfg_pkg::REG_IDX_W-1:0] reg_idx_t;

    // One bit per wait-buffer slot
    // Used for valid, ready, dependency, insert, remove and grant masks
    typedef logic [wb_cfg_pkg::ENTRIES-1:0] entry_mask_t;

    // One bit per source operand
    typedef logic [wb_cfg_pkg::NUM_OPERANDS-1:0] op_mask_t;

    // Free-slot credit count toward the fetcher
    typedef logic [wb_cfg_pkg::CREDIT_W-1:0] credit_t;

endpackage

/* wb_ifs.sv */
// ##############################
// Internal links of the wait buffer
// Entry view for hazard checks, dispatch for the arbiter
// ##############################

`timescale 1ns/1ps

// Snapshot of the stored entries for the hazard check
interface entry_view_if;

    wb_types_pkg::entry_mask_t valid;
    wb_types_pkg::reg_idx_t [wb_cfg_pkg::ENTRIES-1:0] dst;
    wb_types_pkg::reg_idx_t [wb_cfg_pkg::ENTRIES-1:0][wb_cfg_pkg::NUM_OPERANDS-1:0] operands;
    wb_types_pkg::op_mask_t [wb_cfg_pkg::ENTRIES-1:0] op_req;

    modport store (output valid, dst, operands, op_req);
    // Plain reader side
    modport check (input valid, dst, operands, op_req);

endinterface

// Ready entries with their payload, grant comes back
interface dispatch_if;

    wb_types_pkg::entry_mask_t ready;
    wb_types_pkg::tag_t [wb_cfg_pkg::ENTRIES-1:0] tag;
    wb_types_pkg::reg_idx_t [wb_cfg_pkg::ENTRIES-1:0] dst;
    wb_types_pkg::reg_idx_t [wb_cfg_pkg::ENTRIES-1:0][wb_cfg_pkg::NUM_OPERANDS-1:0] operands;
    wb_types_pkg::op_mask_t [wb_cfg_pkg::ENTRIES-1:0] op_req;
    // One-hot, only set in a cycle with an accepted dispatch
    wb_types_pkg::entry_mask_t grant;

    modport store (output ready, tag, dst, operands, op_req, input grant);
    modport arbiter (input ready, tag, dst, operands, op_req, output grant);

endinterface

/* issue_credit_counter.sv */
// ##############################
// Free-slot credits handed to the fetcher
// ##############################

`timescale 1ns/1ps

module issue_credit_counter (
    input  logic clk_i,
    input  logic arst_n_i,
    // Fetch of one instruction
    input  logic take_i,
    // Dispatch or decoded control instruction
    input  logic give_i,
    output logic space_o
);

    wb_types_pkg::credit_t count_q;

    // Take and give together leave the count as it is
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= wb_types_pkg::credit_t'(wb_cfg_pkg::ENTRIES);
        end else if (take_i && !give_i) begin
            count_q <= count_q - 1'b1;
        end else if (give_i && !take_i) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign space_o = (count_q != '0);

    // Fetcher overrun or a credit given back twice
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(take_i && count_q == '0) &&
        !(give_i && !take_i && count_q == wb_types_pkg::credit_t'(wb_cfg_pkg::ENTRIES)))
    else $error("Credit count out of range");

endmodule

/* hazard_check.sv */
// ##############################
// Dependency mask of an instruction coming from decode
// Pure logic on the stored entries
// ##############################

`timescale 1ns/1ps

module hazard_check (
    // Wait for every older entry
    input  logic                      inorder_i,
    input  wb_types_pkg::reg_idx_t    dst_reg_i,
    entry_view_if.check               view,
    output wb_types_pkg::entry_mask_t dep_mask_o
);

    always_comb begin
        dep_mask_o = '0;
        for (int i = 0; i < wb_cfg_pkg::ENTRIES; i++) begin
            if (view.valid[i]) begin
                // In-order mode, all older entries first
                if (inorder_i) begin
                    dep_mask_o[i] = 1'b1;
                end
                // WAW, same destination
                if (view.dst[i] == dst_reg_i) begin
                    dep_mask_o[i] = 1'b1;
                end
                // WAR, an older entry still has to read this register
                for (int k = 0; k < wb_cfg_pkg::NUM_OPERANDS; k++) begin
                    if (view.op_req[i][k] && view.operands[i][k] == dst_reg_i) begin
                        dep_mask_o[i] = 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* entry_store.sv */
// ##############################
// Wait-buffer entries of one warp
// Insert, wake-up, dispatch marking and removal by tag
// ##############################

`timescale 1ns/1ps

module entry_store (
    input  logic clk_i,
    input  logic arst_n_i,

    // From decode
    input  logic                      dec_valid_i,
    input  wb_types_pkg::tag_t        dec_tag_i,
    input  wb_types_pkg::reg_idx_t    dec_dst_reg_i,
    input  wb_types_pkg::op_mask_t    dec_operands_required_i,
    input  wb_types_pkg::op_mask_t    dec_operands_ready_i,
    input  wb_types_pkg::tag_t [wb_cfg_pkg::NUM_OPERANDS-1:0]     dec_operand_tags_i,
    input  wb_types_pkg::reg_idx_t [wb_cfg_pkg::NUM_OPERANDS-1:0] dec_operands_i,
    input  wb_types_pkg::entry_mask_t dep_mask_i,

    // Operand collector has read the operands
    input  logic                      remove_i,
    input  wb_types_pkg::tag_t        remove_tag_i,

    // Result broadcast
    input  logic                      wake_i,
    input  wb_types_pkg::tag_t        wake_tag_i,

    output logic                      full_o,
    entry_view_if.store               view,
    dispatch_if.store                 disp
);

    // ##############################
    // State
    // ##############################

    // Control flags
    wb_types_pkg::entry_mask_t valid_q;
    wb_types_pkg::entry_mask_t dispatched_q;

    // Per-entry payload
    wb_types_pkg::tag_t [wb_cfg_pkg::ENTRIES-1:0]          tag_q;
    wb_types_pkg::reg_idx_t [wb_cfg_pkg::ENTRIES-1:0]      dst_q;
    wb_types_pkg::entry_mask_t [wb_cfg_pkg::ENTRIES-1:0]   dep_q;
    wb_types_pkg::reg_idx_t [wb_cfg_pkg::ENTRIES-1:0][wb_cfg_pkg::NUM_OPERANDS-1:0] opreg_q;
    wb_types_pkg::tag_t [wb_cfg_pkg::ENTRIES-1:0][wb_cfg_pkg::NUM_OPERANDS-1:0]     optag_q;
    wb_types_pkg::op_mask_t [wb_cfg_pkg::ENTRIES-1:0]      opreq_q;
    wb_types_pkg::op_mask_t [wb_cfg_pkg::ENTRIES-1:0]      oprdy_q;

    wb_types_pkg::entry_mask_t insert_mask;
    wb_types_pkg::entry_mask_t remove_mask;

    // ##############################
    // Slot selection
    // ##############################

    assign full_o = &valid_q;

    // Lowest free slot wins, scan runs downward so the last hit is the lowest
    always_comb begin
        insert_mask = '0;
        for (int i = wb_cfg_pkg::ENTRIES - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                insert_mask = '0;
                insert_mask[i] = dec_valid_i;
            end
        end
    end

    // Only a dispatched entry can be retired by the collector
    always_comb begin
        for (int i = 0; i < wb_cfg_pkg::ENTRIES; i++) begin
            remove_mask[i] = remove_i && valid_q[i] && dispatched_q[i]
                             && (tag_q[i] == remove_tag_i);
        end
    end

    // ##############################
    // Registers
    // ##############################

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q      <= '0;
            dispatched_q <= '0;
        end else begin
            valid_q      <= (valid_q & ~remove_mask) | insert_mask;
            // Fresh entries start undispatched
            dispatched_q <= (dispatched_q | disp.grant) & ~insert_mask;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < wb_cfg_pkg::ENTRIES; i++) begin
            // Retired producers no longer block anyone
            dep_q[i] <= dep_q[i] & ~remove_mask;

            // Wake-up on a matching result tag
            for (int k = 0; k < wb_cfg_pkg::NUM_OPERANDS; k++) begin
                if (wake_i && valid_q[i] && !oprdy_q[i][k] && optag_q[i][k] == wake_tag_i) begin
                    oprdy_q[i][k] <= 1'b1;
                end
            end

            if (insert_mask[i]) begin
                tag_q[i]   <= dec_tag_i;
                dst_q[i]   <= dec_dst_reg_i;
                // Entries leaving this cycle are not waited for
                dep_q[i]   <= dep_mask_i & ~remove_mask;
                opreg_q[i] <= dec_operands_i;
                optag_q[i] <= dec_operand_tags_i;
                opreq_q[i] <= dec_operands_required_i;
                // Unused operands never wait
                oprdy_q[i] <= dec_operands_ready_i | ~dec_operands_required_i;
            end
        end
    end

    // ##############################
    // Outputs
    // ##############################

    always_comb begin
        for (int i = 0; i < wb_cfg_pkg::ENTRIES; i++) begin
            disp.ready[i] = valid_q[i] && !dispatched_q[i] && (&oprdy_q[i])
                            && (dep_q[i] == '0);
        end
    end

    assign disp.tag      = tag_q;
    assign disp.dst      = dst_q;
    assign disp.operands = opreg_q;
    assign disp.op_req   = opreq_q;

    assign view.valid    = valid_q;
    assign view.dst      = dst_q;
    assign view.operands = opreg_q;
    assign view.op_req   = opreq_q;

    // ##############################
    // Checks
    // ##############################

    // Credits must keep decode from seeing a full buffer
    assert property (@(posedge clk_i) disable iff (!arst_n_i) dec_valid_i |-> !full_o)
    else $error("Insert into a full wait buffer");

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0(insert_mask) && $onehot0(remove_mask) && $onehot0(disp.grant))
    else $error("Insert, remove or grant mask not one-hot");

    // Tags are unique among live entries
    for (genvar i = 0; i < wb_cfg_pkg::ENTRIES; i++) begin : gen_tag_chk
        for (genvar j = i + 1; j < wb_cfg_pkg::ENTRIES; j++) begin : gen_pair
            assert property (@(posedge clk_i) disable iff (!arst_n_i)
                valid_q[i] && valid_q[j] |-> tag_q[i] != tag_q[j])
            else $error("Entries %0d and %0d share a tag", i, j);
        end
    end

endmodule

/* rr_dispatch.sv */
// ##############################
// Round-robin pick of a ready entry for the operand collector
// Offer is held until the collector accepts it
// ##############################

`timescale 1ns/1ps

module rr_dispatch (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic opc_ready_i,
    dispatch_if.arbiter disp,
    output logic                   valid_o,
    output wb_types_pkg::tag_t     tag_o,
    output wb_types_pkg::reg_idx_t dst_o,
    output wb_types_pkg::op_mask_t op_req_o,
    output wb_types_pkg::reg_idx_t [wb_cfg_pkg::NUM_OPERANDS-1:0] operands_o
);

    // Last granted slot, search starts one above it
    logic [wb_cfg_pkg::ENTRY_IDX_W-1:0] ptr_q;
    // Stalled offer
    logic [wb_cfg_pkg::ENTRY_IDX_W-1:0] sel_idx_q;
    logic                               hold_q;

    logic [wb_cfg_pkg::ENTRY_IDX_W-1:0] search_idx;
    logic [wb_cfg_pkg::ENTRY_IDX_W-1:0] pick_idx;
    logic                               found;
    logic                               accept;

    // Scan offsets downward so the nearest ready slot after ptr_q wins
    always_comb begin
        int unsigned idx;
        search_idx = ptr_q;
        found      = 1'b0;
        for (int k = wb_cfg_pkg::ENTRIES; k >= 1; k--) begin
            idx = ptr_q + k;
            if (idx >= wb_cfg_pkg::ENTRIES) begin
                idx = idx - wb_cfg_pkg::ENTRIES;
            end
            if (disp.ready[idx]) begin
                search_idx = wb_cfg_pkg::ENTRY_IDX_W'(idx);
                found      = 1'b1;
            end
        end
    end

    // A held entry stays ready, nothing but a grant clears it
    assign pick_idx = hold_q ? sel_idx_q : search_idx;
    assign valid_o  = hold_q || found;
    assign accept   = valid_o && opc_ready_i;

    always_comb begin
        disp.grant = '0;
        if (accept) begin
            disp.grant[pick_idx] = 1'b1;
        end
    end

    // Payload straight from the stored entry
    assign tag_o      = disp.tag[pick_idx];
    assign dst_o      = disp.dst[pick_idx];
    assign op_req_o   = disp.op_req[pick_idx];
    assign operands_o = disp.operands[pick_idx];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // First search starts at slot 0
            ptr_q     <= wb_cfg_pkg::ENTRY_IDX_W'(wb_cfg_pkg::ENTRIES - 1);
            sel_idx_q <= '0;
            hold_q    <= 1'b0;
        end else if (accept) begin
            ptr_q  <= pick_idx;
            hold_q <= 1'b0;
        end else if (valid_o) begin
            sel_idx_q <= pick_idx;
            hold_q    <= 1'b1;
        end
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        |disp.grant |-> $onehot(disp.grant) && ((disp.grant & ~disp.ready) == '0))
    else $error("Grant not one-hot or on a non-ready entry");

    // Back-pressure keeps the offer in place
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_o && !opc_ready_i |=> valid_o && $stable(tag_o))
    else $error("Stalled dispatch offer changed");

endmodule

/* wait_buffer.sv */
// ##############################
// Per-warp wait buffer of the issue stage
// Top level with plain ports toward fetch, decode, collector and EUs
// ##############################

`timescale 1ns/1ps

module wait_buffer (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic inorder_execution_i,

    // Fetcher
    input  logic fe_handshake_i,
    output logic ib_space_available_o,

    // Decoder
    input  logic                   dec_control_decoded_i,
    input  logic                   dec_valid_i,
    output logic                   wb_ready_o,
    input  wb_types_pkg::tag_t     dec_tag_i,
    input  wb_types_pkg::reg_idx_t dec_dst_reg_i,
    input  wb_types_pkg::op_mask_t dec_operands_required_i,
    input  wb_types_pkg::op_mask_t dec_operands_ready_i,
    input  wb_types_pkg::tag_t [wb_cfg_pkg::NUM_OPERANDS-1:0]     dec_operand_tags_i,
    input  wb_types_pkg::reg_idx_t [wb_cfg_pkg::NUM_OPERANDS-1:0] dec_operands_i,

    // Operand collector
    input  logic                   opc_ready_i,
    output logic                   disp_valid_o,
    output wb_types_pkg::tag_t     disp_tag_o,
    output wb_types_pkg::reg_idx_t disp_dst_o,
    output wb_types_pkg::op_mask_t disp_operands_required_o,
    output wb_types_pkg::reg_idx_t [wb_cfg_pkg::NUM_OPERANDS-1:0] disp_operands_o,
    input  logic                   opc_eu_handshake_i,
    input  wb_types_pkg::tag_t     opc_eu_tag_i,

    // Execution units
    input  logic                   eu_valid_i,
    input  wb_types_pkg::tag_t     eu_tag_i
);

    wb_types_pkg::entry_mask_t dep_mask;
    logic                      full;
    logic                      credit_give;

    entry_view_if view_if ();
    dispatch_if   disp_if ();

    // Dispatch handshake or a control instruction returns a credit
    assign credit_give = (disp_valid_o && opc_ready_i) || dec_control_decoded_i;
    assign wb_ready_o  = !full;

    issue_credit_counter credit_inst (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .take_i   (fe_handshake_i),
        .give_i   (credit_give),
        .space_o  (ib_space_available_o)
    );

    hazard_check hazard_inst (
        .inorder_i  (inorder_execution_i),
        .dst_reg_i  (dec_dst_reg_i),
        .view       (view_if),
        .dep_mask_o (dep_mask)
    );

    entry_store store_inst (
        .clk_i                   (clk_i),
        .arst_n_i                (arst_n_i),
        .dec_valid_i             (dec_valid_i),
        .dec_tag_i               (dec_tag_i),
        .dec_dst_reg_i           (dec_dst_reg_i),
        .dec_operands_required_i (dec_operands_required_i),
        .dec_operands_ready_i    (dec_operands_ready_i),
        .dec_operand_tags_i      (dec_operand_tags_i),
        .dec_operands_i          (dec_operands_i),
        .dep_mask_i              (dep_mask),
        .remove_i                (opc_eu_handshake_i),
        .remove_tag_i            (opc_eu_tag_i),
        .wake_i                  (eu_valid_i),
        .wake_tag_i              (eu_tag_i),
        .full_o                  (full),
        .view                    (view_if),
        .disp                    (disp_if)
    );

    rr_dispatch dispatch_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .opc_ready_i (opc_ready_i),
        .disp        (disp_if),
        .valid_o     (disp_valid_o),
        .tag_o       (disp_tag_o),
        .dst_o       (disp_dst_o),
        .op_req_o    (disp_operands_required_o),
        .operands_o  (disp_operands_o)
    );

endmodule

/* tb_clk_gen.sv */
// ##############################
// Clock and reset source of the wait-buffer testbench
// ##############################

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset released on a rising edge, the DUT still sees it low there
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

/* tb_wait_buffer.sv */
// ##############################
// Directed testbench of the per-warp wait buffer
// Credits, dispatch, wake-up, hazards and arbitration order
// ##############################

`timescale 1ns/1ps

module tb_wait_buffer;

    localparam int CLK_PERIOD_NS = 40;
    localparam int RESET_CYCLES  = 10;
    // Longest wait for one dispatch offer
    localparam int WAIT_LIMIT    = 50;
    // Worst case per test, waits included
    localparam int CREDIT_CYCLES = 20;
    localparam int SIMPLE_CYCLES = 10 + WAIT_LIMIT;
    localparam int WAKE_CYCLES   = 30 + WAIT_LIMIT;
    localparam int HAZARD_CYCLES = 40 + 4 * WAIT_LIMIT;
    localparam int ORDER_CYCLES  = 80 + 8 * WAIT_LIMIT;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + CREDIT_CYCLES + SIMPLE_CYCLES
                                   + WAKE_CYCLES + HAZARD_CYCLES + ORDER_CYCLES;

    typedef wb_types_pkg::reg_idx_t [wb_cfg_pkg::NUM_OPERANDS-1:0] opregs_t;
    typedef wb_types_pkg::tag_t [wb_cfg_pkg::NUM_OPERANDS-1:0] optags_t;

    logic                   clk;
    logic                   arst_n;
    logic                   inorder_execution;
    logic                   fe_handshake;
    logic                   dec_control_decoded;
    logic                   dec_valid;
    wb_types_pkg::tag_t     dec_tag;
    wb_types_pkg::reg_idx_t dec_dst_reg;
    wb_types_pkg::op_mask_t dec_operands_required;
    wb_types_pkg::op_mask_t dec_operands_ready;
    optags_t                dec_operand_tags;
    opregs_t                dec_operands;
    logic                   opc_ready;
    logic                   opc_eu_handshake;
    wb_types_pkg::tag_t     opc_eu_tag;
    logic                   eu_valid;
    wb_types_pkg::tag_t     eu_tag;
    logic                   ib_space_available;
    logic                   wb_ready;
    logic                   disp_valid;
    wb_types_pkg::tag_t     disp_tag;
    wb_types_pkg::reg_idx_t disp_dst;
    wb_types_pkg::op_mask_t disp_operands_required;
    opregs_t                disp_operands;
    int                     fail_count;
    int unsigned            seed_val;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) clk_gen_inst (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    wait_buffer wait_buffer_inst (
        .clk_i                    (clk),
        .arst_n_i                 (arst_n),
        .inorder_execution_i      (inorder_execution),
        .fe_handshake_i           (fe_handshake),
        .ib_space_available_o     (ib_space_available),
        .dec_control_decoded_i    (dec_control_decoded),
        .dec_valid_i              (dec_valid),
        .wb_ready_o               (wb_ready),
        .dec_tag_i                (dec_tag),
        .dec_dst_reg_i            (dec_dst_reg),
        .dec_operands_required_i  (dec_operands_required),
        .dec_operands_ready_i     (dec_operands_ready),
        .dec_operand_tags_i       (dec_operand_tags),
        .dec_operands_i           (dec_operands),
        .opc_ready_i              (opc_ready),
        .disp_valid_o             (disp_valid),
        .disp_tag_o               (disp_tag),
        .disp_dst_o               (disp_dst),
        .disp_operands_required_o (disp_operands_required),
        .disp_operands_o          (disp_operands),
        .opc_eu_handshake_i       (opc_eu_handshake),
        .opc_eu_tag_i             (opc_eu_tag),
        .eu_valid_i               (eu_valid),
        .eu_tag_i                 (eu_tag)
    );

    // ##############################
    // Helpers
    // ##############################

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            fail_count++;
            stop_run($sformatf("Fail %s: expected 0x%0h, actual 0x%0h", test, expected, actual));
        end
    endtask

    // Upper half of the register file, kept apart from the destinations used here
    function automatic wb_types_pkg::reg_idx_t random_operand_reg();
        return wb_types_pkg::reg_idx_t'(32'h20 | ($urandom() & 32'h1f));
    endfunction

    // Fetch and decode of one instruction in the same cycle
    task automatic insert_instr(input wb_types_pkg::tag_t tag, input wb_types_pkg::reg_idx_t dst,
                                input wb_types_pkg::op_mask_t req,
                                input wb_types_pkg::op_mask_t rdy,
                                input optags_t optags, input opregs_t regs);
        @(negedge clk);
        check_value("insert_space", 1, ib_space_available);
        check_value("insert_ready", 1, wb_ready);
        @(posedge clk);
        fe_handshake          <= 1'b1;
        dec_valid             <= 1'b1;
        dec_tag               <= tag;
        dec_dst_reg           <= dst;
        dec_operands_required <= req;
        dec_operands_ready    <= rdy;
        dec_operand_tags      <= optags;
        dec_operands          <= regs;
        @(posedge clk);
        fe_handshake <= 1'b0;
        dec_valid    <= 1'b0;
    endtask

    // Collector ready until one offer is taken
    task automatic take_dispatch(input string test, output wb_types_pkg::tag_t tag);
        int cycles;
        cycles = 0;
        @(posedge clk);
        opc_ready <= 1'b1;
        @(negedge clk);
        while (!disp_valid) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_run($sformatf("No dispatch offer in %s within %0d cycles", test, WAIT_LIMIT));
            end
            @(negedge clk);
        end
        tag = disp_tag;
        // Handshake completes on this edge
        @(posedge clk);
        opc_ready <= 1'b0;
    endtask

    // Collector ready, yet nothing may be offered
    task automatic expect_no_offer(input string test, input int cycles);
        @(posedge clk);
        opc_ready <= 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            check_value(test, 0, disp_valid);
        end
        @(posedge clk);
        opc_ready <= 1'b0;
    endtask

    task automatic remove_entry(input wb_types_pkg::tag_t tag);
        @(posedge clk);
        opc_eu_handshake <= 1'b1;
        opc_eu_tag       <= tag;
        @(posedge clk);
        opc_eu_handshake <= 1'b0;
    endtask

    task automatic broadcast_result(input wb_types_pkg::tag_t tag);
        @(posedge clk);
        eu_valid <= 1'b1;
        eu_tag   <= tag;
        @(posedge clk);
        eu_valid <= 1'b0;
    endtask

    // ##############################
    // Tests
    // ##############################

    task automatic credit_flow();
        @(negedge clk);
        check_value("credits_reset_space", 1, ib_space_available);
        check_value("credits_reset_ready", 1, wb_ready);
        check_value("credits_reset_disp", 0, disp_valid);
        // Four fetches use up every credit
        repeat (wb_cfg_pkg::ENTRIES) begin
            @(posedge clk);
            fe_handshake <= 1'b1;
        end
        @(posedge clk);
        fe_handshake <= 1'b0;
        @(negedge clk);
        check_value("credits_empty", 0, ib_space_available);
        // A decoded control instruction gives one back
        @(posedge clk);
        dec_control_decoded <= 1'b1;
        @(posedge clk);
        dec_control_decoded <= 1'b0;
        @(negedge clk);
        check_value("credits_control_return", 1, ib_space_available);
        // Refill to a full count for the later tests
        repeat (wb_cfg_pkg::ENTRIES - 1) begin
            @(posedge clk);
            dec_control_decoded <= 1'b1;
        end
        @(posedge clk);
        dec_control_decoded <= 1'b0;
    endtask

    task automatic simple_dispatch();
        opregs_t            regs;
        wb_types_pkg::tag_t tag;
        regs[0] = random_operand_reg();
        regs[1] = random_operand_reg();
        insert_instr(3'd1, 6'd5, 2'b11, 2'b11, '0, regs);
        // Offer in the cycle after the insert edge
        @(negedge clk);
        check_value("simple_valid", 1, disp_valid);
        check_value("simple_tag", 1, disp_tag);
        check_value("simple_dst", 5, disp_dst);
        check_value("simple_req", 2'b11, disp_operands_required);
        check_value("simple_operands", regs, disp_operands);
        take_dispatch("simple_dispatch", tag);
        check_value("simple_dispatched_tag", 1, tag);
        remove_entry(tag);
        @(negedge clk);
        check_value("simple_empty", 0, disp_valid);
    endtask

    task automatic operand_wakeup();
        opregs_t            regs;
        wb_types_pkg::tag_t tag;
        regs[0] = random_operand_reg();
        regs[1] = random_operand_reg();
        // Operand 1 waits for the result with tag 5
        insert_instr(3'd2, 6'd7, 2'b11, 2'b01, {3'd5, 3'd0}, regs);
        expect_no_offer("wakeup_before", 4);
        broadcast_result(3'd6);
        expect_no_offer("wakeup_other_tag", 3);
        broadcast_result(3'd5);
        // Eligible one cycle after the broadcast edge
        @(negedge clk);
        check_value("wakeup_valid", 1, disp_valid);
        take_dispatch("wakeup", tag);
        check_value("wakeup_tag", 2, tag);
        remove_entry(tag);
    endtask

    task automatic register_hazards();
        wb_types_pkg::tag_t tag;
        // WAW on r20
        insert_instr(3'd3, 6'd20, 2'b11, 2'b11, '0, {6'd41, 6'd40});
        take_dispatch("waw_first", tag);
        check_value("waw_first_tag", 3, tag);
        insert_instr(3'd4, 6'd20, 2'b11, 2'b11, '0, {6'd43, 6'd42});
        expect_no_offer("waw_blocked", 4);
        remove_entry(3'd3);
        take_dispatch("waw_second", tag);
        check_value("waw_second_tag", 4, tag);
        remove_entry(3'd4);
        // WAR, second writes r44 that the first still reads
        insert_instr(3'd5, 6'd21, 2'b11, 2'b11, '0, {6'd45, 6'd44});
        take_dispatch("war_first", tag);
        check_value("war_first_tag", 5, tag);
        insert_instr(3'd6, 6'd44, 2'b11, 2'b11, '0, {6'd47, 6'd46});
        expect_no_offer("war_blocked", 4);
        remove_entry(3'd5);
        take_dispatch("war_second", tag);
        check_value("war_second_tag", 6, tag);
        remove_entry(3'd6);
    endtask

    task automatic arbitration_order();
        opregs_t                         regs;
        wb_types_pkg::tag_t              tag;
        wb_types_pkg::tag_t              held_tag;
        wb_types_pkg::tag_t              exp_tag;
        wb_types_pkg::tag_t              order_q[$];
        logic [wb_cfg_pkg::NUM_TAGS-1:0] seen;
        seen = '0;
        // Tag 0 goes in first and is the only ready entry when the offer appears
        held_tag = wb_types_pkg::tag_t'(0);
        // Fill the buffer under back-pressure, later inserts must not move the offer
        for (int i = 0; i < wb_cfg_pkg::ENTRIES; i++) begin
            regs[0] = random_operand_reg();
            regs[1] = random_operand_reg();
            insert_instr(wb_types_pkg::tag_t'(i), wb_types_pkg::reg_idx_t'(10 + i),
                         2'b11, 2'b11, '0, regs);
            @(negedge clk);
            check_value("arb_offer", 1, disp_valid);
            check_value("arb_stall_tag", held_tag, disp_tag);
        end
        check_value("arb_full", 0, wb_ready);
        check_value("arb_no_credit", 0, ib_space_available);
        repeat (5) begin
            @(negedge clk);
            check_value("arb_stall_valid", 1, disp_valid);
            check_value("arb_stall_tag", held_tag, disp_tag);
        end
        // Every entry exactly once
        for (int i = 0; i < wb_cfg_pkg::ENTRIES; i++) begin
            take_dispatch("arbitration", tag);
            check_value("arb_tag_once", 0, seen[tag]);
            seen[tag] = 1'b1;
        end
        check_value("arb_all_tags", (32'd1 << wb_cfg_pkg::ENTRIES) - 1, seen);
        @(negedge clk);
        check_value("arb_drained", 0, disp_valid);
        for (int i = 0; i < wb_cfg_pkg::ENTRIES; i++) begin
            remove_entry(wb_types_pkg::tag_t'(i));
        end

        // In-order mode, tags deliberately not ascending
        @(posedge clk);
        inorder_execution <= 1'b1;
        order_q = {3'd6, 3'd4, 3'd7, 3'd5};
        foreach (order_q[i]) begin
            regs[0] = random_operand_reg();
            regs[1] = random_operand_reg();
            insert_instr(order_q[i], wb_types_pkg::reg_idx_t'(14 + i), 2'b11, 2'b11, '0, regs);
        end
        while (order_q.size() > 0) begin
            exp_tag = order_q.pop_front();
            take_dispatch("inorder", tag);
            check_value("inorder_tag", exp_tag, tag);
            // Younger entries wait until this one is removed
            expect_no_offer("inorder_blocked", 2);
            remove_entry(tag);
        end
        @(posedge clk);
        inorder_execution <= 1'b0;
    endtask

    // ##############################
    // Sequence and watchdog
    // ##############################

    initial begin
        seed_val              = $urandom(32'hcc92);
        fail_count            = 0;
        inorder_execution     = 1'b0;
        fe_handshake          = 1'b0;
        dec_control_decoded   = 1'b0;
        dec_valid             = 1'b0;
        dec_tag               = '0;
        dec_dst_reg           = '0;
        dec_operands_required = '0;
        dec_operands_ready    = '0;
        dec_operand_tags      = '0;
        dec_operands          = '0;
        opc_ready             = 1'b0;
        opc_eu_handshake      = 1'b0;
        opc_eu_tag            = '0;
        eu_valid              = 1'b0;
        eu_tag                = '0;
        wait (arst_n === 1'b1);
        @(posedge clk);
        credit_flow();
        simple_dispatch();
        operand_wakeup();
        register_hazards();
        arbitration_order();
        if (fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Twice the summed worst case of all tests
    initial begin
        #(TOTAL_CYCLES * 2 * CLK_PERIOD_NS);
        stop_run("Watchdog expired before the tests finished");
    end

endmodule

/* sources.f */
wb_cfg_pkg.sv
wb_types_pkg.sv
wb_ifs.sv
issue_credit_counter.sv
hazard_check.sv
entry_store.sv
rr_dispatch.sv
wait_buffer.sv
tb_clk_gen.sv
tb_wait_buffer.sv

/* Bender.yml */
package:
  name: wait_buffer

sources:
  - wb_cfg_pkg.sv
  - wb_types_pkg.sv
  - wb_ifs.sv
  - issue_credit_counter.sv
  - hazard_check.sv
  - entry_store.sv
  - rr_dispatch.sv
  - wait_buffer.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_wait_buffer.sv
